//--- rtl/mips_pkg.sv
package mips_pkg;

    // Machine word and register file geometry
    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 1 << REG_ADDR_W;

    // Data memory is word addressed
    localparam int DMEM_ADDR_W   = 8;
    localparam int DMEM_DEPTH    = 1 << DMEM_ADDR_W;
    // Byte offset bits dropped from the ALU result
    localparam int WORD_OFFSET_W = 2;

    // Bundle leaving execute, held in EX/MEM
    typedef struct packed {
        logic [DATA_W-1:0]     pc4;
        logic [DATA_W-1:0]     instr;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] rd;
        // MEM controls
        logic                  mem_read;
        logic                  mem_write;
        // WB controls
        logic                  mem_to_reg;
        logic                  reg_write;
    } ex_mem_t;

    // Bundle leaving the memory stage, held in MEM/WB
    typedef struct packed {
        logic [DATA_W-1:0]     pc4;
        logic [DATA_W-1:0]     instr;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     mem_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_to_reg;
        logic                  reg_write;
    } mem_wb_t;

    // Retire bundle, observed at the top level
    typedef struct packed {
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
        logic [DATA_W-1:0]     pc4;
        logic [DATA_W-1:0]     instr;
    } wb_t;

endpackage

//--- rtl/pipe_stage_reg.sv
`timescale 1ns/1ns

module pipe_stage_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_arst_n,
    input  T     i_d,
    output T     o_q
);

    T stage_q;

    // Whole payload clears, so controls come out of reset inactive
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            stage_q <= '0;
        end
        else
        begin
            stage_q <= i_d;
        end
    end

    assign o_q = stage_q;

endmodule

//--- rtl/data_memory.sv
`timescale 1ns/1ns

module data_memory
    import mips_pkg::*;
(
    input  logic    i_clk,
    input  ex_mem_t i_stage,
    output mem_wb_t o_stage
);

    logic [DATA_W-1:0]      mem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] word_idx;
    logic [DATA_W-1:0]      rd_word;
    logic                   wr_en;
    logic                   rd_en;

    // Word index from the byte address
    assign word_idx = i_stage.alu_result[WORD_OFFSET_W +: DMEM_ADDR_W];

    assign wr_en = i_stage.mem_write;
    assign rd_en = i_stage.mem_read;

    // Store lands on the edge that ends the MEM cycle
    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            mem[word_idx] <= i_stage.store_data;
        end
    end

    // Asynchronous read gives zero when not loading
    always_comb
    begin
        if (rd_en)
        begin
            rd_word = mem[word_idx];
        end
        else
        begin
            rd_word = '0;
        end
    end

    // Build the MEM/WB bundle
    always_comb
    begin
        o_stage            = '0;
        o_stage.pc4        = i_stage.pc4;
        o_stage.instr      = i_stage.instr;
        o_stage.alu_result = i_stage.alu_result;
        o_stage.mem_data   = rd_word;
        o_stage.rd         = i_stage.rd;
        o_stage.mem_to_reg = i_stage.mem_to_reg;
        o_stage.reg_write  = i_stage.reg_write;
    end

endmodule

//--- rtl/writeback_regfile.sv
`timescale 1ns/1ns

module writeback_regfile
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  mem_wb_t               i_stage,
    input  logic [REG_ADDR_W-1:0] i_rs_addr,
    input  logic [REG_ADDR_W-1:0] i_rt_addr,
    output logic [DATA_W-1:0]     o_rs_data,
    output logic [DATA_W-1:0]     o_rt_data,
    output wb_t                   o_wb
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [DATA_W-1:0] wb_data;
    logic              wr_en;

    // Load result or ALU result
    always_comb
    begin
        if (i_stage.mem_to_reg)
        begin
            wb_data = i_stage.mem_data;
        end
        else
        begin
            wb_data = i_stage.alu_result;
        end
    end

    // $zero is never written
    assign wr_en = i_stage.reg_write && (i_stage.rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            regs[i_stage.rd] <= wb_data;
        end
    end

    // Read ports see the value before a same-cycle write
    always_comb
    begin
        if (i_rs_addr == '0)
        begin
            o_rs_data = '0;
        end
        else
        begin
            o_rs_data = regs[i_rs_addr];
        end
    end

    always_comb
    begin
        if (i_rt_addr == '0)
        begin
            o_rt_data = '0;
        end
        else
        begin
            o_rt_data = regs[i_rt_addr];
        end
    end

    // Retire bundle follows MEM/WB directly
    always_comb
    begin
        o_wb           = '0;
        o_wb.reg_write = i_stage.reg_write;
        o_wb.rd        = i_stage.rd;
        o_wb.data      = wb_data;
        o_wb.pc4       = i_stage.pc4;
        o_wb.instr     = i_stage.instr;
    end

endmodule

//--- rtl/mem_wb_backend.sv
`timescale 1ns/1ns

module mem_wb_backend
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  ex_mem_t               i_ex,
    input  logic [REG_ADDR_W-1:0] i_rs_addr,
    input  logic [REG_ADDR_W-1:0] i_rt_addr,
    output logic [DATA_W-1:0]     o_rs_data,
    output logic [DATA_W-1:0]     o_rt_data,
    output wb_t                   o_wb
);

    // EX/MEM register output
    ex_mem_t ex_mem_q;
    // Memory stage result, before MEM/WB
    mem_wb_t mem_stage;
    // MEM/WB register output
    mem_wb_t mem_wb_q;

    pipe_stage_reg #(
        .T (ex_mem_t)
    ) u_ex_mem (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_d      (i_ex),
        .o_q      (ex_mem_q)
    );

    data_memory u_dmem (
        .i_clk   (i_clk),
        .i_stage (ex_mem_q),
        .o_stage (mem_stage)
    );

    pipe_stage_reg #(
        .T (mem_wb_t)
    ) u_mem_wb (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_d      (mem_stage),
        .o_q      (mem_wb_q)
    );

    // Write-back and register file feeding the decode read ports
    writeback_regfile u_wb (
        .i_clk     (i_clk),
        .i_stage   (mem_wb_q),
        .i_rs_addr (i_rs_addr),
        .i_rt_addr (i_rt_addr),
        .o_rs_data (o_rs_data),
        .o_rt_data (o_rt_data),
        .o_wb      (o_wb)
    );

endmodule

//--- bench/mem_wb_backend_assert.sv
`timescale 1ns/1ns

module mem_wb_backend_assert
    import mips_pkg::*;
(
    input logic                  i_clk,
    input logic                  i_arst_n,
    input ex_mem_t               i_ex,
    input logic [REG_ADDR_W-1:0] i_rs_addr,
    input logic [DATA_W-1:0]     o_rs_data,
    input wb_t                   o_wb
);

    // No retire while held in reset
    a_reset_quiet : assert property (
        @(posedge i_clk) (!i_arst_n && $past(!i_arst_n)) |-> !o_wb.reg_write
    ) else $error("o_wb.reg_write high during reset");

    // Two stages between the EX input and the retire bundle
    a_write_latency : assert property (
        @(posedge i_clk)
        (i_arst_n && $past(i_arst_n) && $past(i_arst_n, 2))
            |-> (o_wb.reg_write == $past(i_ex.reg_write, 2))
    ) else $error("o_wb.reg_write does not follow i_ex.reg_write by two cycles");

    a_zero_reads_zero : assert property (
        @(posedge i_clk) (i_rs_addr == '0) |-> (o_rs_data == '0)
    ) else $error("register zero read back nonzero");

endmodule

bind mem_wb_backend mem_wb_backend_assert u_assert (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_ex      (i_ex),
    .i_rs_addr (i_rs_addr),
    .o_rs_data (o_rs_data),
    .o_wb      (o_wb)
);

//--- bench/tb_mem_wb_backend.sv
`timescale 1ns/1ns

module tb_mem_wb_backend
    import mips_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 200;
    // Issued bundles over all tests with margin for drains and reads
    localparam int ISSUE_BUDGET = NUM_RANDOM + 100;
    localparam int MAX_CYCLES   = 3 * ISSUE_BUDGET + 100;

    // Control nibble is {mem_read, mem_write, mem_to_reg, reg_write}
    localparam logic [3:0] CTRL_BUBBLE = 4'b0000;
    localparam logic [3:0] CTRL_ALU    = 4'b0001;
    localparam logic [3:0] CTRL_STORE  = 4'b0100;
    localparam logic [3:0] CTRL_LOAD   = 4'b1011;

    logic                  i_clk;
    logic                  i_arst_n;
    ex_mem_t               i_ex;
    logic [REG_ADDR_W-1:0] i_rs_addr;
    logic [REG_ADDR_W-1:0] i_rt_addr;
    logic [DATA_W-1:0]     o_rs_data;
    logic [DATA_W-1:0]     o_rt_data;
    wb_t                   o_wb;

    // Reference model state
    logic [DATA_W-1:0] shadow_regs [NUM_REGS];
    logic [DATA_W-1:0] shadow_mem  [DMEM_DEPTH];
    wb_t               exp_q [$];

    logic [DATA_W-1:0] pc_next;
    integer            seed;
    int                error_count = 0;
    int                test_count = 0;
    int                test_start_errors = 0;
    int                cycle_count = 0;

    mem_wb_backend u_mem_wb_backend (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_ex      (i_ex),
        .i_rs_addr (i_rs_addr),
        .i_rt_addr (i_rt_addr),
        .o_rs_data (o_rs_data),
        .o_rt_data (o_rt_data),
        .o_wb      (o_wb)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    initial
    begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end

    task automatic compare_wb(input string name, input wb_t expected, input wb_t actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_word(input string name, input logic [DATA_W-1:0] expected,
                                input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("Test %-14s %0d error(s)", name, error_count - test_start_errors);
    endtask

    // Predict the retire bundle and update the shadows in issue order
    task automatic model_bundle(input ex_mem_t b);
        logic [DMEM_ADDR_W-1:0] idx;
        logic [DATA_W-1:0]      load_word;
        wb_t                    expected;
        idx = b.alu_result[9:2];
        load_word = b.mem_read ? shadow_mem[idx] : '0;
        if (b.mem_write)
        begin
            shadow_mem[idx] = b.store_data;
        end
        expected.reg_write = b.reg_write;
        expected.rd        = b.rd;
        expected.data      = b.mem_to_reg ? load_word : b.alu_result;
        expected.pc4       = b.pc4;
        expected.instr     = b.instr;
        if (b.reg_write && (b.rd != 5'd0))
        begin
            shadow_regs[b.rd] = expected.data;
        end
        exp_q.push_back(expected);
    endtask

    // Check what retires in this cycle and then drive the next bundle
    task automatic step(input ex_mem_t b);
        wb_t expected;
        @(negedge i_clk);
        if (exp_q.size() >= 2)
        begin
            expected = exp_q.pop_front();
            compare_wb("o_wb", expected, o_wb);
        end
        i_ex = b;
        model_bundle(b);
    endtask

    task automatic issue(input logic [REG_ADDR_W-1:0] rd, input logic [DATA_W-1:0] alu,
                         input logic [DATA_W-1:0] sdata, input logic [3:0] ctrl);
        ex_mem_t b;
        b.pc4        = pc_next;
        b.instr      = $random(seed);
        b.alu_result = alu;
        b.store_data = sdata;
        b.rd         = rd;
        b.mem_read   = ctrl[3];
        b.mem_write  = ctrl[2];
        b.mem_to_reg = ctrl[1];
        b.reg_write  = ctrl[0];
        pc_next = pc_next + 32'd4;
        step(b);
    endtask

    task automatic issue_bubble();
        logic [DATA_W-1:0] rnd;
        rnd = $random(seed);
        issue(rnd[4:0], $random(seed), $random(seed), CTRL_BUBBLE);
    endtask

    // Enough bubbles for the last write to reach the register file
    task automatic drain();
        repeat (3) issue_bubble();
    endtask

    task automatic check_pair(input logic [REG_ADDR_W-1:0] ra, input logic [REG_ADDR_W-1:0] rb);
        logic [DATA_W-1:0] exp_a;
        logic [DATA_W-1:0] exp_b;
        issue_bubble();
        exp_a = (ra == 5'd0) ? '0 : shadow_regs[ra];
        exp_b = (rb == 5'd0) ? '0 : shadow_regs[rb];
        i_rs_addr = ra;
        i_rt_addr = rb;
        #(CLK_PERIOD / 4);
        compare_word($sformatf("o_rs_data[%0d]", ra), exp_a, o_rs_data);
        compare_word($sformatf("o_rt_data[%0d]", rb), exp_b, o_rt_data);
    endtask

    task automatic test_after_reset();
        start_test();
        compare_wb("o_wb", '0, o_wb);
        end_test("after_reset");
    endtask

    task automatic test_alu_writeback();
        start_test();
        issue(5'd3, 32'h1234_5678, $random(seed), CTRL_ALU);
        issue(5'd4, 32'hdead_beef, $random(seed), CTRL_ALU);
        // Later write to the same register wins
        issue(5'd3, 32'h0bad_f00d, $random(seed), CTRL_ALU);
        drain();
        check_pair(5'd3, 5'd4);
        check_pair(5'd4, 5'd3);
        end_test("alu_writeback");
    endtask

    task automatic test_store_load();
        start_test();
        issue(5'd0, 32'h0000_0040, 32'hcafe_0001, CTRL_STORE);
        // Load right behind the store
        issue(5'd5, 32'h0000_0040, 32'h0000_0000, CTRL_LOAD);
        issue(5'd0, 32'h0000_0044, 32'h5a5a_0002, CTRL_STORE);
        issue_bubble();
        // Upper address bits fall outside the memory index
        issue(5'd6, 32'hffff_fc44, 32'h0000_0000, CTRL_LOAD);
        drain();
        check_pair(5'd5, 5'd6);
        end_test("store_load");
    endtask

    task automatic test_reg_zero();
        start_test();
        issue(5'd0, 32'h7777_7777, 32'h0000_0000, CTRL_ALU);
        issue(5'd0, 32'h0000_0040, 32'h0000_0000, CTRL_LOAD);
        drain();
        check_pair(5'd0, 5'd0);
        end_test("reg_zero");
    endtask

    task automatic test_bubbles();
        start_test();
        repeat (8) issue_bubble();
        drain();
        check_pair(5'd3, 5'd4);
        check_pair(5'd5, 5'd6);
        // Memory words still hold the earlier stores
        issue(5'd7, 32'h0000_0040, 32'h0000_0000, CTRL_LOAD);
        issue(5'd8, 32'h0000_0044, 32'h0000_0000, CTRL_LOAD);
        drain();
        check_pair(5'd7, 5'd8);
        end_test("bubbles");
    endtask

    task automatic test_random_stream();
        logic [DATA_W-1:0]     rnd;
        logic [DATA_W-1:0]     alu;
        logic [REG_ADDR_W-1:0] rd;
        start_test();
        // Known contents for the 16 words and 8 registers in use
        for (int i = 0; i < 16; i++)
        begin
            issue(5'd0, 32'(i << 2), $random(seed), CTRL_STORE);
        end
        for (int r = 1; r < 8; r++)
        begin
            issue(5'(r), $random(seed), 32'h0000_0000, CTRL_ALU);
        end
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            rnd = $random(seed);
            alu = $random(seed);
            alu = {alu[31:10], 4'b0000, rnd[3:0], alu[1:0]};
            rd  = {2'b00, rnd[6:4]};
            case (rnd[9:8])
                2'd0: issue(rd, alu, $random(seed), CTRL_BUBBLE);
                2'd1: issue(rd, alu, $random(seed), CTRL_ALU);
                2'd2: issue(rd, alu, $random(seed), CTRL_STORE);
                default: issue(rd, alu, $random(seed), CTRL_LOAD);
            endcase
        end
        drain();
        for (int r = 0; r < 8; r += 2)
        begin
            check_pair(5'(r), 5'(r + 1));
        end
        end_test("random_stream");
    endtask

    initial
    begin
        seed      = 32'h8437_e645;
        pc_next   = 32'h0040_0004;
        i_arst_n  = 1'b0;
        i_ex      = '0;
        i_rs_addr = '0;
        i_rt_addr = '0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;

        test_after_reset();
        test_alu_writeback();
        test_store_load();
        test_reg_zero();
        test_bubbles();
        test_random_stream();

        $display("Tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/mips_pkg.sv
rtl/pipe_stage_reg.sv
rtl/data_memory.sv
rtl/writeback_regfile.sv
rtl/mem_wb_backend.sv
bench/mem_wb_backend_assert.sv
bench/tb_mem_wb_backend.sv

//--- Makefile
TOP = tb_mem_wb_backend
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f $(wildcard rtl/*.sv bench/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# Verdict comes from the log, not the exit status
sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then exit 1; fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
